//--- Makefile
TOP := tb_zip_dbg

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

//--- design/cpu_ctrl.sv
/*
 * CPU control registers
 * Power-on reset hold, halt, step, clear-cache and catch
 * Status word assembly
 */
`timescale 1ns/10ps

module cpu_ctrl #(
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED   = 1'b1
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  i_cpu_reset,
	// From the debug slave
	input  logic                  i_cmd_write,
	input  zipdbg_pkg::dbg_word_t i_cmd_data,
	input  zipdbg_pkg::dbg_strb_t i_cmd_strb,
	input  logic                  i_reg_write,
	input  logic                  i_dbg_we,
	input  logic                  i_write_ready,
	input  logic                  i_write_stall,
	// From the CPU
	input  logic                  i_cpu_dbg_stall,
	input  logic                  i_cpu_break,
	input  logic [1:0]            i_cpu_dbg_cc,
	input  logic                  i_interrupt,
	// Commands
	output logic                  o_cmd_reset,
	output logic                  o_cmd_halt,
	output logic                  o_cmd_step,
	output logic                  o_cmd_clear_cache,
	output zipdbg_pkg::dbg_word_t o_status
);

	localparam int CW = $clog2(RESET_DURATION);

	logic [CW-1:0] hold_count;
	logic          reset_hold;
	logic          catch_en;
	logic          reset_req, release_req, halt_req, step_req, clear_req;

	// Control bit decode, strobe lane chosen by bit position
	assign reset_req   = i_cmd_write && i_cmd_strb[zipdbg_pkg::RESET_BIT/8]
		&& i_cmd_data[zipdbg_pkg::RESET_BIT];
	assign release_req = i_cmd_write && i_cmd_strb[zipdbg_pkg::HALT_BIT/8]
		&& !i_cmd_data[zipdbg_pkg::HALT_BIT];
	assign halt_req    = i_cmd_write && i_cmd_strb[zipdbg_pkg::HALT_BIT/8]
		&& i_cmd_data[zipdbg_pkg::HALT_BIT];
	assign step_req    = i_cmd_write && i_cmd_strb[zipdbg_pkg::STEP_BIT/8]
		&& i_cmd_data[zipdbg_pkg::STEP_BIT];
	assign clear_req   = i_cmd_write && i_cmd_strb[zipdbg_pkg::CLEAR_CACHE_BIT/8]
		&& i_cmd_data[zipdbg_pkg::CLEAR_CACHE_BIT];

	////////////////////////////////////////////////////////////////////
	// Reset hold
	////////////////////////////////////////////////////////////////////

	// Counts the cycles left after the one that leaves reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			hold_count <= CW'(RESET_DURATION - 1);
		else if (hold_count != '0)
			hold_count <= hold_count - 1'b1;
	end

	assign reset_hold = (hold_count != '0);

	// Uncaught break restarts the CPU
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_reset <= 1'b1;
		else if (reset_hold)
			o_cmd_reset <= 1'b1;
		else if (i_cpu_break && !catch_en)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= reset_req;
	end

	////////////////////////////////////////////////////////////////////
	// Halt, step, clear cache, catch
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_cmd_halt <= START_HALTED;
		else if (i_cpu_reset && !i_write_ready && !i_write_stall)
			o_cmd_halt <= START_HALTED;
		else if (o_cmd_reset && START_HALTED)
			o_cmd_halt <= START_HALTED;
		else
		begin
			// Release only from a full stop with no register write left
			if (!i_dbg_we && !i_cpu_dbg_stall && (release_req || step_req))
				o_cmd_halt <= 1'b0;
			// Later lines win over the release
			if (i_cpu_break && catch_en)
				o_cmd_halt <= 1'b1;
			if (halt_req && !step_req)
				o_cmd_halt <= 1'b1;
			if (i_reg_write)
				o_cmd_halt <= 1'b1;
			if (o_cmd_step || o_cmd_clear_cache || clear_req)
				o_cmd_halt <= 1'b1;
		end
	end

	// Step lasts until the CPU stops again
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_cmd_step <= 1'b0;
		else if (step_req)
			o_cmd_step <= 1'b1;
		else if (!i_cpu_dbg_stall)
			o_cmd_step <= 1'b0;
	end

	// Cache clear needs halt in the same write
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_cmd_clear_cache <= 1'b0;
		else if (clear_req && halt_req)
			o_cmd_clear_cache <= 1'b1;
		else if (o_cmd_halt && !i_cpu_dbg_stall)
			o_cmd_clear_cache <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			catch_en <= START_HALTED;
		else if (i_cmd_write && i_cmd_strb[zipdbg_pkg::CATCH_BIT/8])
			catch_en <= i_cmd_data[zipdbg_pkg::CATCH_BIT];
	end

	// Status word, unlisted bits read zero
	always_comb
	begin
		o_status = '0;
		o_status[zipdbg_pkg::ST_HALT_REQ]  = o_cmd_halt;
		o_status[zipdbg_pkg::ST_HALTED]    = !i_cpu_dbg_stall;
		o_status[zipdbg_pkg::ST_RESET]     = o_cmd_reset;
		o_status[zipdbg_pkg::ST_CATCH]     = catch_en;
		o_status[zipdbg_pkg::ST_SLEEP]     = i_cpu_dbg_cc[0];
		o_status[zipdbg_pkg::ST_GIE]       = i_cpu_dbg_cc[1];
		o_status[zipdbg_pkg::ST_INTERRUPT] = i_interrupt;
		o_status[zipdbg_pkg::ST_BREAK]     = i_cpu_break;
	end

endmodule

//--- design/dbg_axil_slave.sv
/*
 * AXI-lite debug slave
 * Skid buffers on AW, W and AR
 * Control and CPU-register space decode, register write latch, read return
 */
`timescale 1ns/10ps

module dbg_axil_slave #(
	parameter int ADDR_WIDTH = 8
) (
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	// AXI-lite write
	input  logic                        i_awvalid,
	output logic                        o_awready,
	input  logic [ADDR_WIDTH-1:0]       i_awaddr,
	input  logic                        i_wvalid,
	output logic                        o_wready,
	input  zipdbg_pkg::dbg_word_t       i_wdata,
	input  zipdbg_pkg::dbg_strb_t       i_wstrb,
	output logic                        o_bvalid,
	input  logic                        i_bready,
	output logic [1:0]                  o_bresp,
	// AXI-lite read
	input  logic                        i_arvalid,
	output logic                        o_arready,
	input  logic [ADDR_WIDTH-1:0]       i_araddr,
	output logic                        o_rvalid,
	input  logic                        i_rready,
	output zipdbg_pkg::dbg_word_t       o_rdata,
	output logic [1:0]                  o_rresp,
	// CPU debug port
	input  logic                        i_cpu_dbg_stall,
	input  zipdbg_pkg::dbg_word_t       i_dbg_rdata,
	output logic                        o_dbg_we,
	output zipdbg_pkg::dbg_reg_t        o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t       o_dbg_wdata,
	output zipdbg_pkg::dbg_reg_t        o_dbg_rreg,
	// Control block
	input  zipdbg_pkg::dbg_word_t       i_status,
	output logic                        o_cmd_write,
	output zipdbg_pkg::dbg_word_t       o_cmd_data,
	output zipdbg_pkg::dbg_strb_t       o_cmd_strb,
	output logic                        o_reg_write,
	output logic                        o_write_ready,
	output logic                        o_write_stall
);

	localparam int AW = ADDR_WIDTH - zipdbg_pkg::DBG_LSB;

	typedef logic [AW-1:0] waddr_t;

	// Data and strobes share one W buffer
	typedef struct packed {
		zipdbg_pkg::dbg_strb_t strb;
		zipdbg_pkg::dbg_word_t data;
	} wpay_t;

	logic   aw_valid, w_valid, ar_valid;
	waddr_t aw_addr, ar_addr;
	wpay_t  w_pay;
	logic   write_ready, read_ready;
	logic   reg_write, write_stall;
	logic   read_pend;

	////////////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////////////

	dbg_skidbuffer #(.T_DATA(waddr_t)) u_awskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid), .o_ready(o_awready),
		.i_data(i_awaddr[ADDR_WIDTH-1:zipdbg_pkg::DBG_LSB]),
		.o_valid(aw_valid), .i_ready(write_ready), .o_data(aw_addr)
	);

	dbg_skidbuffer #(.T_DATA(wpay_t)) u_wskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid), .o_ready(o_wready),
		.i_data(wpay_t'{strb: i_wstrb, data: i_wdata}),
		.o_valid(w_valid), .i_ready(write_ready), .o_data(w_pay)
	);

	// CPU still busy with the last register write
	assign write_stall = o_dbg_we && i_cpu_dbg_stall;

	// Both halves present, CPU free or not needed, B channel open
	assign write_ready = aw_valid && w_valid
		&& ((w_pay.strb == '0) || !aw_addr[zipdbg_pkg::SPACE_BIT] || !write_stall)
		&& (!o_bvalid || i_bready);

	// Only full-word writes reach the register file
	assign reg_write = write_ready && (w_pay.strb == '1)
		&& aw_addr[zipdbg_pkg::SPACE_BIT];

	// Pending register write, held until the CPU stops stalling
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_we <= 1'b0;
		else if (!write_stall)
			o_dbg_we <= reg_write;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_dbg_wreg  <= aw_addr[4:0];
			o_dbg_wdata <= w_pay.data;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (write_ready)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	assign o_bresp = zipdbg_pkg::RESP_OKAY;

	// Control space writes go to the command registers
	assign o_cmd_write   = write_ready && !aw_addr[zipdbg_pkg::SPACE_BIT];
	assign o_cmd_data    = w_pay.data;
	assign o_cmd_strb    = w_pay.strb;
	assign o_reg_write   = reg_write;
	assign o_write_ready = write_ready;
	assign o_write_stall = write_stall;

	////////////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////////////

	dbg_skidbuffer #(.T_DATA(waddr_t)) u_arskd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid), .o_ready(o_arready),
		.i_data(i_araddr[ADDR_WIDTH-1:zipdbg_pkg::DBG_LSB]),
		.o_valid(ar_valid), .i_ready(read_ready), .o_data(ar_addr)
	);

	// One CPU read in flight, R channel must be free
	assign read_ready = ar_valid && !read_pend && (!o_rvalid || i_rready);

	// CPU sees the register index in the accept cycle
	assign o_dbg_rreg = ar_addr[4:0];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			read_pend <= 1'b0;
		else
			read_pend <= read_ready && ar_addr[zipdbg_pkg::SPACE_BIT];
	end

	// Status reads answer next cycle, CPU reads one cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_ready && !ar_addr[zipdbg_pkg::SPACE_BIT]) || read_pend;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= read_pend ? i_dbg_rdata : i_status;
	end

	assign o_rresp = zipdbg_pkg::RESP_OKAY;

endmodule

//--- design/dbg_skidbuffer.sv
/*
 * One-deep skid buffer
 * Payload passes straight through, one item held on a stall
 */
`timescale 1ns/10ps

module dbg_skidbuffer #(
	parameter type T_DATA = logic [31:0]
) (
	input  logic  S_AXI_ACLK,
	input  logic  S_AXI_ARESETN,
	// Upstream
	input  logic  i_valid,
	output logic  o_ready,
	input  T_DATA i_data,
	// Downstream
	output logic  o_valid,
	input  logic  i_ready,
	output T_DATA o_data
);

	logic  r_valid;
	T_DATA r_data;

	// Item held when downstream stalls on a fresh input
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && o_valid && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whenever the buffer is empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready is a registered level
	assign o_ready = !r_valid;

	// Held item goes first
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

//--- design/zip_dbg_top.sv
/*
 * Debug and control shell top level
 * AXI-lite debug slave joined to the CPU control block
 */
`timescale 1ns/10ps

module zip_dbg_top #(
	parameter int ADDR_WIDTH     = 8,
	parameter int RESET_DURATION = 10,
	parameter bit START_HALTED   = 1'b1
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  i_interrupt,
	input  logic                  i_cpu_reset,
	// AXI-lite debug slave
	input  logic                  S_DBG_AWVALID,
	output logic                  S_DBG_AWREADY,
	input  logic [ADDR_WIDTH-1:0] S_DBG_AWADDR,
	input  logic                  S_DBG_WVALID,
	output logic                  S_DBG_WREADY,
	input  zipdbg_pkg::dbg_word_t S_DBG_WDATA,
	input  zipdbg_pkg::dbg_strb_t S_DBG_WSTRB,
	output logic                  S_DBG_BVALID,
	input  logic                  S_DBG_BREADY,
	output logic [1:0]            S_DBG_BRESP,
	input  logic                  S_DBG_ARVALID,
	output logic                  S_DBG_ARREADY,
	input  logic [ADDR_WIDTH-1:0] S_DBG_ARADDR,
	output logic                  S_DBG_RVALID,
	input  logic                  S_DBG_RREADY,
	output zipdbg_pkg::dbg_word_t S_DBG_RDATA,
	output logic [1:0]            S_DBG_RRESP,
	// CPU debug port
	input  logic                  i_cpu_dbg_stall,
	input  logic                  i_cpu_break,
	input  logic [1:0]            i_cpu_dbg_cc,
	input  zipdbg_pkg::dbg_word_t i_dbg_rdata,
	output logic                  o_dbg_we,
	output zipdbg_pkg::dbg_reg_t  o_dbg_wreg,
	output zipdbg_pkg::dbg_word_t o_dbg_wdata,
	output zipdbg_pkg::dbg_reg_t  o_dbg_rreg,
	output logic                  o_cmd_halt,
	output logic                  o_cmd_reset,
	output logic                  o_cmd_step,
	output logic                  o_cmd_clear_cache,
	// Accounting
	output logic                  o_halted,
	output logic                  o_gie
);

	logic                  cmd_write, reg_write, write_ready, write_stall;
	zipdbg_pkg::dbg_word_t cmd_data, status;
	zipdbg_pkg::dbg_strb_t cmd_strb;

	dbg_axil_slave #(.ADDR_WIDTH(ADDR_WIDTH)) u_slave (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awvalid(S_DBG_AWVALID), .o_awready(S_DBG_AWREADY), .i_awaddr(S_DBG_AWADDR),
		.i_wvalid(S_DBG_WVALID), .o_wready(S_DBG_WREADY),
		.i_wdata(S_DBG_WDATA), .i_wstrb(S_DBG_WSTRB),
		.o_bvalid(S_DBG_BVALID), .i_bready(S_DBG_BREADY), .o_bresp(S_DBG_BRESP),
		.i_arvalid(S_DBG_ARVALID), .o_arready(S_DBG_ARREADY), .i_araddr(S_DBG_ARADDR),
		.o_rvalid(S_DBG_RVALID), .i_rready(S_DBG_RREADY),
		.o_rdata(S_DBG_RDATA), .o_rresp(S_DBG_RRESP),
		.i_cpu_dbg_stall(i_cpu_dbg_stall), .i_dbg_rdata(i_dbg_rdata),
		.o_dbg_we(o_dbg_we), .o_dbg_wreg(o_dbg_wreg),
		.o_dbg_wdata(o_dbg_wdata), .o_dbg_rreg(o_dbg_rreg),
		.i_status(status), .o_cmd_write(cmd_write),
		.o_cmd_data(cmd_data), .o_cmd_strb(cmd_strb),
		.o_reg_write(reg_write), .o_write_ready(write_ready),
		.o_write_stall(write_stall)
	);

	cpu_ctrl #(
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) u_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset),
		.i_cmd_write(cmd_write), .i_cmd_data(cmd_data), .i_cmd_strb(cmd_strb),
		.i_reg_write(reg_write), .i_dbg_we(o_dbg_we),
		.i_write_ready(write_ready), .i_write_stall(write_stall),
		.i_cpu_dbg_stall(i_cpu_dbg_stall), .i_cpu_break(i_cpu_break),
		.i_cpu_dbg_cc(i_cpu_dbg_cc), .i_interrupt(i_interrupt),
		.o_cmd_reset(o_cmd_reset), .o_cmd_halt(o_cmd_halt),
		.o_cmd_step(o_cmd_step), .o_cmd_clear_cache(o_cmd_clear_cache),
		.o_status(status)
	);

	// Accounting taps on the status word
	assign o_halted = status[zipdbg_pkg::ST_HALTED];
	assign o_gie    = status[zipdbg_pkg::ST_GIE];

endmodule

//--- design/zipdbg_pkg.sv
/*
 * Shared debug definitions
 * Word, strobe and register-index types
 * Control and status bit positions, AXI response code
 */
package zipdbg_pkg;

	// Debug bus word
	localparam int DBG_WIDTH = 32;
	localparam int DBG_LSB = 2;

	typedef logic [DBG_WIDTH-1:0]   dbg_word_t;
	typedef logic [DBG_WIDTH/8-1:0] dbg_strb_t;
	typedef logic [4:0]             dbg_reg_t;

	// Word-address bit choosing control (0) or CPU registers (1)
	localparam int SPACE_BIT = 5;

	// Control register bits
	localparam int HALT_BIT        = 0;
	localparam int STEP_BIT        = 2;
	localparam int RESET_BIT       = 3;
	localparam int CLEAR_CACHE_BIT = 4;
	localparam int CATCH_BIT       = 5;

	// Status word bits
	localparam int ST_HALT_REQ  = 0;
	localparam int ST_HALTED    = 1;
	localparam int ST_RESET     = 3;
	localparam int ST_CATCH     = 5;
	localparam int ST_SLEEP     = 8;
	localparam int ST_GIE       = 9;
	localparam int ST_INTERRUPT = 10;
	localparam int ST_BREAK     = 11;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- filelist.f
design/zipdbg_pkg.sv
design/dbg_skidbuffer.sv
design/dbg_axil_slave.sv
design/cpu_ctrl.sv
design/zip_dbg_top.sv
testbench/tb_zip_dbg.sv

//--- testbench/tb_zip_dbg.sv
/*
 * Testbench for the debug and control shell
 * Clock, reset, LFSR-driven AXI-lite traffic, CPU model
 * Reference model of halt and catch, checks and watchdog
 */
`timescale 1ns/10ps

module tb_zip_dbg;

	localparam int ADDR_WIDTH     = 8;
	localparam int RESET_DURATION = 10;
	localparam bit START_HALTED   = 1'b1;
	localparam int NUM_OPS        = 200;
	localparam int WAIT_LIMIT     = 64;
	localparam int CLK_PERIOD     = 4;
	// Three channel waits per op at most, plus reset and break tests
	localparam longint WATCHDOG_NS = (NUM_OPS + 40) * 3 * WAIT_LIMIT * CLK_PERIOD;

	logic S_AXI_ACLK, S_AXI_ARESETN, i_interrupt, i_cpu_reset;
	logic S_DBG_AWVALID, S_DBG_AWREADY, S_DBG_WVALID, S_DBG_WREADY;
	logic S_DBG_BVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_ARREADY;
	logic S_DBG_RVALID, S_DBG_RREADY;
	logic [ADDR_WIDTH-1:0] S_DBG_AWADDR, S_DBG_ARADDR;
	logic [31:0] S_DBG_WDATA, S_DBG_RDATA, i_dbg_rdata, o_dbg_wdata;
	logic [3:0]  S_DBG_WSTRB;
	logic [1:0]  S_DBG_BRESP, S_DBG_RRESP, i_cpu_dbg_cc;
	logic        i_cpu_dbg_stall, i_cpu_break, o_dbg_we;
	logic [4:0]  o_dbg_wreg, o_dbg_rreg;
	logic        o_cmd_halt, o_cmd_reset, o_cmd_step, o_cmd_clear_cache, o_halted, o_gie;

	// Stimulus and CPU model LFSR states, plus reference model
	logic [31:0] stim_lfsr, cpu_lfsr;
	logic [31:0] cpu_regs [32];
	logic [31:0] ref_regs [32];
	logic        m_halt, m_catch;
	int          errors, checks;

	zip_dbg_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.RESET_DURATION(RESET_DURATION),
		.START_HALTED(START_HALTED)
	) DUT (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD/2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////////////
	// Random numbers
	////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////////////
	// CPU model
	////////////////////////////////////////////////////////////////////

	// Registered read port
	always @(posedge S_AXI_ACLK)
		i_dbg_rdata <= cpu_regs[o_dbg_rreg];

	// Runs (stalls) at random unless halt is requested
	always @(negedge S_AXI_ACLK)
	begin
		cpu_lfsr = lfsr_step(cpu_lfsr);
		i_cpu_dbg_stall = !o_cmd_halt && cpu_lfsr[0];
		// Pending write lands in a cycle with no stall
		if (o_dbg_we && !i_cpu_dbg_stall)
			cpu_regs[o_dbg_wreg] = o_dbg_wdata;
	end

	////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic fail_plain(input string what);
		errors++;
		$display("%0t ns: %s", $time, what);
	endtask

	// Status word predicted from the bit layout
	function automatic logic [31:0] expected_status();
		logic [31:0] s;
		s = '0;
		s[zipdbg_pkg::ST_HALT_REQ]  = m_halt;
		s[zipdbg_pkg::ST_HALTED]    = m_halt;
		s[zipdbg_pkg::ST_CATCH]     = m_catch;
		s[zipdbg_pkg::ST_SLEEP]     = i_cpu_dbg_cc[0];
		s[zipdbg_pkg::ST_GIE]       = i_cpu_dbg_cc[1];
		s[zipdbg_pkg::ST_INTERRUPT] = i_interrupt;
		return s;
	endfunction

	task automatic do_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int  n;
		bit  aw_done, w_done, b_done;
		aw_done = 0;
		w_done = 0;
		b_done = 0;
		n = 0;
		S_DBG_AWADDR = addr;
		S_DBG_WDATA = data;
		S_DBG_WSTRB = strb;
		S_DBG_AWVALID = 1'b1;
		S_DBG_WVALID = 1'b1;
		while (!(aw_done && w_done) && n < WAIT_LIMIT)
		begin
			// Handshake at the coming rising edge
			if (S_DBG_AWVALID && S_DBG_AWREADY)
				aw_done = 1;
			if (S_DBG_WVALID && S_DBG_WREADY)
				w_done = 1;
			@(negedge S_AXI_ACLK);
			if (aw_done)
				S_DBG_AWVALID = 1'b0;
			if (w_done)
				S_DBG_WVALID = 1'b0;
			n++;
		end
		if (!(aw_done && w_done))
			fail_plain("Write address or data was never accepted");
		n = 0;
		while (!b_done && n < WAIT_LIMIT)
		begin
			S_DBG_BREADY = rand_bits(1);
			if (S_DBG_BVALID && S_DBG_BREADY)
			begin
				check_value("S_DBG_BRESP", S_DBG_BRESP, zipdbg_pkg::RESP_OKAY);
				b_done = 1;
			end
			@(negedge S_AXI_ACLK);
			n++;
		end
		S_DBG_BREADY = 1'b0;
		if (!b_done)
			fail_plain("No write response arrived");
		// Exactly one response per write
		check_value("S_DBG_BVALID after response", S_DBG_BVALID, 0);
	endtask

	task automatic do_read(input logic [7:0] addr, input logic [31:0] exp,
		input logic [31:0] mask);
		int n;
		bit ar_done, r_done;
		ar_done = 0;
		r_done = 0;
		n = 0;
		S_DBG_ARADDR = addr;
		S_DBG_ARVALID = 1'b1;
		while (!ar_done && n < WAIT_LIMIT)
		begin
			if (S_DBG_ARREADY)
				ar_done = 1;
			@(negedge S_AXI_ACLK);
			n++;
		end
		S_DBG_ARVALID = 1'b0;
		if (!ar_done)
			fail_plain("Read address was never accepted");
		n = 0;
		while (!r_done && n < WAIT_LIMIT)
		begin
			S_DBG_RREADY = rand_bits(1);
			if (S_DBG_RVALID && S_DBG_RREADY)
			begin
				check_value("S_DBG_RDATA", S_DBG_RDATA & mask, exp & mask);
				check_value("S_DBG_RRESP", S_DBG_RRESP, zipdbg_pkg::RESP_OKAY);
				r_done = 1;
			end
			@(negedge S_AXI_ACLK);
			n++;
		end
		S_DBG_RREADY = 1'b0;
		if (!r_done)
			fail_plain("No read response arrived");
		check_value("S_DBG_RVALID after response", S_DBG_RVALID, 0);
	endtask

	task automatic status_read();
		logic [31:0] mask;
		mask = 32'hffff_ffff;
		// Halted follows the random stall while running
		if (!m_halt)
			mask[zipdbg_pkg::ST_HALTED] = 1'b0;
		repeat (3) @(negedge S_AXI_ACLK);
		do_read({1'b0, 5'(rand_bits(5)), 2'b00}, expected_status(), mask);
		check_value("o_gie", o_gie, i_cpu_dbg_cc[1]);
		// CPU model never stalls while halt is requested
		if (m_halt)
			check_value("o_halted", o_halted, 1);
	endtask

	task automatic control_write(input logic halt, input logic catch_bit);
		logic [31:0] d;
		d = '0;
		d[zipdbg_pkg::HALT_BIT] = halt;
		d[zipdbg_pkg::CATCH_BIT] = catch_bit;
		do_write({1'b0, 5'(rand_bits(5)), 2'b00}, d, 4'hf);
		m_catch = catch_bit;
		m_halt = halt;
	endtask

	task automatic wait_write_taken();
		int n;
		n = 0;
		while (o_dbg_we && n < WAIT_LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (o_dbg_we)
			fail_plain("CPU never took the register write");
	endtask

	task automatic pulse_break();
		@(negedge S_AXI_ACLK);
		i_cpu_break = 1'b1;
		@(negedge S_AXI_ACLK);
		i_cpu_break = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [4:0]  idx;
		logic [31:0] data;
		logic [3:0]  strb;
		int          hold;
		errors = 0;
		checks = 0;
		stim_lfsr = 32'hcc0d02ce;
		cpu_lfsr = 32'hcc0d02ce;
		S_AXI_ARESETN = 1'b0;
		{i_interrupt, i_cpu_reset, i_cpu_break, i_cpu_dbg_stall} = '0;
		{S_DBG_AWVALID, S_DBG_WVALID, S_DBG_BREADY, S_DBG_ARVALID, S_DBG_RREADY} = '0;
		S_DBG_AWADDR = '0;
		S_DBG_ARADDR = '0;
		S_DBG_WDATA = '0;
		S_DBG_WSTRB = '0;
		i_cpu_dbg_cc = '0;
		i_dbg_rdata <= '0;
		// Fill pattern spans the whole index
		for (int i = 0; i < 32; i++)
		begin
			cpu_regs[i] = 32'ha5c3_0000 ^ (i * 32'h0101_0101);
			ref_regs[i] = cpu_regs[i];
		end
		m_halt = START_HALTED;
		m_catch = START_HALTED;
		repeat (10) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		// Reset hold, counted from the release edge
		hold = 0;
		while (o_cmd_reset && hold < RESET_DURATION + 5)
		begin
			hold++;
			@(negedge S_AXI_ACLK);
		end
		check_value("o_cmd_reset hold cycles", hold, RESET_DURATION);
		check_value("o_cmd_halt after reset", o_cmd_halt, START_HALTED);
		check_value("o_cmd_step after reset", o_cmd_step, 0);
		check_value("o_cmd_clear_cache after reset", o_cmd_clear_cache, 0);
		i_cpu_dbg_cc = rand_bits(2);
		i_interrupt = rand_bits(1);

		for (int op = 0; op < NUM_OPS; op++)
		begin
			idx = rand_bits(5);
			case (rand_bits(2))
				0: control_write(rand_bits(1), rand_bits(1));
				1:
				begin
					data = rand_bits(32);
					do_write({1'b1, idx, 2'b00}, data, 4'hf);
					ref_regs[idx] = data;
					m_halt = 1'b1;
					wait_write_taken();
					check_value("CPU register after write", cpu_regs[idx], data);
				end
				2:
				begin
					strb = rand_bits(4);
					if (strb == 4'hf)
						strb = 4'h7;
					do_write({1'b1, idx, 2'b00}, rand_bits(32), strb);
					repeat (2) @(negedge S_AXI_ACLK);
					check_value("o_dbg_we on partial write", o_dbg_we, 0);
					check_value("CPU register after partial write", cpu_regs[idx],
						ref_regs[idx]);
				end
				default:
					if (rand_bits(1))
						status_read();
					else
						do_read({1'b1, idx, 2'b00}, ref_regs[idx], 32'hffff_ffff);
			endcase
			check_value("o_cmd_halt", o_cmd_halt, m_halt);
		end

		// Caught break halts a running CPU
		control_write(1'b0, 1'b1);
		repeat (3) @(negedge S_AXI_ACLK);
		pulse_break();
		m_halt = 1'b1;
		check_value("o_cmd_halt on caught break", o_cmd_halt, 1);
		check_value("o_cmd_reset on caught break", o_cmd_reset, 0);
		status_read();

		// Uncaught break pulses the CPU reset
		control_write(1'b1, 1'b0);
		pulse_break();
		check_value("o_cmd_reset on uncaught break", o_cmd_reset, 1);
		@(negedge S_AXI_ACLK);
		check_value("o_cmd_reset after break", o_cmd_reset, 0);
		m_halt = START_HALTED;
		status_read();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the test did not finish in time");
		$display("Checks run: %0d, errors: %0d", checks, errors + 1);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
